// File: tb/obj_vectors.hex
// @000 table writes: count, then (address data) pairs, one object per line
// @100 ROM words by rom_addr[7:0]; @200 test count, then per test:
// vrender flip npairs, then 8 (x pixel) pairs, pixel = {pal, pen, prio}
@000
001d
0000 2320 0002 000a 0003 0002 0004 0010 0005 0501
0008 2928 000a 0064 000b 0001 000c 8020 000d 2a02
0010 7060
0018 3232
0020 3432 0022 00c8 0023 0000 0024 0030 0025 0100
0028 3830 002a 00ca 002b 0001 002c 0000 002d 0303 002f 0031
0030 f000
0038 3432 003a 00fa 003b 0000 003c 0030 003d 0100
@124 1203 4f00
@128 56f0
@12c 7f00
@141 f065 4321
@160 1111 f000
@164 22f0
@200
0007
0020 0000 0004 000a 0145 000b 0149 000d 014d 000e 0151 0000 0000 0000 0000 0000 0000 0000 0000
0021 0000 0002 000a 0155 000b 0159 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0022 0000 0001 000a 015d 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0028 0000 0006 0064 0a86 0065 0a8a 0066 0a8e 0067 0a92 0068 0a96 0069 0a9a 0000 0000 0000 0000
0032 0000 0004 00c8 0044 00c9 0044 00ca 00cb 00cb 00cb 0000 0000 0000 0000 0000 0000 0000 0000
003c 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
00b7 0001 0006 0064 0a86 0065 0a8a 0066 0a8e 0067 0a92 0068 0a96 0069 0a9a 0000 0000 0000 0000

// File: tb.f
+incdir+common
common/obj_pkg.sv
verilog/obj_table.sv
obj_scan/obj_scan.sv
obj_draw/obj_draw.sv
verilog/obj_linebuf.sv
verilog/obj_top.sv
tb/obj_checker.sv
tb/obj_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the sprite engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f tb.f --top-module obj_tb -o obj_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/obj_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1

// File: tb/obj_tb.sv
/*
  Sprite engine testbench: clock, reset, object table loading,
  one-cycle ROM model, line sequencing and run timeout
*/
`timescale 1ns/1ns
`include "obj_defs.svh"

module obj_tb;
    import obj_pkg::*;

    localparam int ROM_BASE   = 256;   // ROM words in the vector file
    localparam int TEST_BASE  = 512;   // Test count, then the test rows
    localparam int TEST_WORDS = 19;    // vrender, flip, count, 8 pairs

    logic                   clk;
    logic                   rst;
    logic                   cpu_we;
    logic [`OBJ_TBL_AW-1:0] cpu_addr;
    logic [15:0]            cpu_din;
    logic                   hstart;
    logic [8:0]             vrender;
    logic [`OBJ_LINE_W-1:0] hdump;
    logic                   flip;
    logic [19:0]            rom_addr;
    logic [15:0]            rom_data = '0;
    obj_pixel_t             obj_pxl;

    logic [15:0]            vec [0:1023];
    logic [11:0]            exp_line [0:319];
    logic                   check_en;
    logic [7:0]             test_num;
    int                     test_count;
    int                     fail_count;
    int                     error_count;
    int                     cycles = 0;
    int                     cycle_limit = 0;
    int                     n_tests;

    obj_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .hstart   (hstart),
        .vrender  (vrender),
        .hdump    (hdump),
        .flip     (flip),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .obj_pxl  (obj_pxl)
    );

    obj_checker u_chk (
        .clk         (clk),
        .check_en    (check_en),
        .test_num    (test_num),
        .hdump       (hdump),
        .obj_pxl     (obj_pxl),
        .exp_line    (exp_line),
        .test_count  (test_count),
        .fail_count  (fail_count),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Sprite ROM, data one cycle after the address
    always @(posedge clk) begin
        rom_data <= vec[ROM_BASE + int'(rom_addr[7:0])];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Count and (address, data) pairs at the start of the file
    task automatic load_table();
        int n;
        n = int'(vec[0]);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            cpu_we   = 1'b1;
            cpu_addr = vec[1 + 2 * i][`OBJ_TBL_AW-1:0];
            cpu_din  = vec[2 + 2 * i];
        end
        @(negedge clk);
        cpu_we = 1'b0;
    endtask

    task automatic sweep_line(input logic [8:0] vr, input int width, input logic en);
        for (int x = 0; x < width; x++) begin
            @(negedge clk);
            vrender  = vr;
            hdump    = 9'(x);
            check_en = en;
        end
        @(negedge clk);
        check_en = 1'b0;
        hdump    = '0;
    endtask

    task automatic draw_line(input logic [8:0] vr, input logic fl);
        @(negedge clk);
        vrender = vr;
        flip    = fl;
        hstart  = 1'b1;
        @(negedge clk);
        hstart = 1'b0;
        // Scanner back in idle and drawer done
        while (u_dut.u_scan.st != 0 || u_dut.dr_start || u_dut.dr_busy) begin
            @(negedge clk);
        end
    endtask

    task automatic set_expected(input int base);
        int n;
        for (int x = 0; x < 320; x++) begin
            exp_line[x] = '0;
        end
        n = int'(vec[base + 2]);
        for (int k = 0; k < n; k++) begin
            exp_line[vec[base + 3 + 2 * k][8:0]] = vec[base + 4 + 2 * k][11:0];
        end
    endtask

    initial begin
        int base;
        for (int i = 0; i < 1024; i++) begin
            vec[i] = {6'h3f, 10'(i)};
        end
        $readmemh("tb/obj_vectors.hex", vec);
        rst      = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_din  = '0;
        hstart   = 1'b0;
        vrender  = '0;
        hdump    = '0;
        flip     = 1'b0;
        check_en = 1'b0;
        test_num = '0;
        n_tests     = int'(vec[TEST_BASE]);
        cycle_limit = 2000 * (n_tests + 1);   // One extra slot for setup

        repeat (4) @(negedge clk);
        rst = 1'b0;
        load_table();
        sweep_line(9'd0, 512, 1'b0);    // Both banks start empty
        sweep_line(9'd1, 512, 1'b0);

        for (int t = 0; t < n_tests; t++) begin
            base     = TEST_BASE + 1 + t * TEST_WORDS;
            test_num = 8'(t + 1);
            set_expected(base);
            draw_line(vec[base][8:0], vec[base + 1][0]);
            sweep_line(vec[base][8:0] + 9'd1, 320, 1'b1);
            repeat (3) @(negedge clk);
        end

        $display("tests %0d, failed %0d, mismatches %0d",
                 test_count, fail_count, error_count);
        if (fail_count == 0 && n_tests > 0 && test_count == n_tests) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb/obj_checker.sv
/*
  Playback monitor: compares obj_pxl with the expected line
  one cycle after each hdump and reports each test line
*/
`timescale 1ns/1ns

module obj_checker (
    input  logic                clk,
    input  logic                check_en,
    input  logic [7:0]          test_num,
    input  logic [8:0]          hdump,
    input  obj_pkg::obj_pixel_t obj_pxl,
    input  logic [11:0]         exp_line [0:319],
    output int                  test_count,
    output int                  fail_count,
    output int                  error_count
);
    import obj_pkg::*;

    logic       en_q = 1'b0;
    logic [8:0] hd_q = '0;     // x that obj_pxl belongs to
    logic       was_on = 1'b0;
    int         line_errs = 0;

    initial begin
        test_count  = 0;
        fail_count  = 0;
        error_count = 0;
    end

    always @(posedge clk) begin
        en_q <= check_en;
        hd_q <= hdump;
    end

    // Output and x are both settled at the falling edge
    always @(negedge clk) begin
        if (en_q) begin
            if (obj_pxl !== exp_line[hd_q]) begin
                $display("mismatch obj_pxl test %0d x %h: got %h, expected %h",
                         test_num, hd_q, obj_pxl, exp_line[hd_q]);
                line_errs++;
                error_count++;
            end
        end else if (was_on) begin
            test_count++;
            if (line_errs != 0) begin
                fail_count++;
                $display("check %0d: bad, %0d mismatches", test_num, line_errs);
            end else begin
                $display("check %0d: ok", test_num);
            end
            line_errs = 0;
        end
        was_on = en_q;
    end

endmodule

// File: verilog/obj_top.sv
/*
  Sprite engine top: object table, scanner, drawer and
  line buffer
*/
`timescale 1ns/1ns
`include "obj_defs.svh"

module obj_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    cpu_we,
    input  logic [`OBJ_TBL_AW-1:0]  cpu_addr,
    input  logic [15:0]             cpu_din,

    input  logic                    hstart,
    input  logic [8:0]              vrender,
    input  logic [`OBJ_LINE_W-1:0]  hdump,
    input  logic                    flip,

    output logic [19:0]             rom_addr,
    input  logic [15:0]             rom_data,

    output obj_pkg::obj_pixel_t     obj_pxl
);
    import obj_pkg::*;

    logic [`OBJ_TBL_AW-1:0] tbl_addr;
    logic [15:0]            tbl_din;
    logic [15:0]            tbl_dout;
    logic                   tbl_we;
    logic                   dr_start;
    logic                   dr_busy;
    draw_cmd_t              dr_cmd;
    logic                   lb_we;
    logic [`OBJ_LINE_W-1:0] lb_x;
    obj_pixel_t             lb_pxl;

    obj_table u_table (
        .clk      (clk),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .tbl_addr (tbl_addr),
        .tbl_we   (tbl_we),
        .tbl_din  (tbl_din),
        .tbl_dout (tbl_dout)
    );

    obj_scan u_scan (
        .clk      (clk),
        .rst      (rst),
        .tbl_addr (tbl_addr),
        .tbl_din  (tbl_din),
        .tbl_we   (tbl_we),
        .tbl_dout (tbl_dout),
        .hstart   (hstart),
        .vrender  (vrender),
        .flip     (flip),
        .dr_start (dr_start),
        .dr_cmd   (dr_cmd),
        .dr_busy  (dr_busy)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .dr_start (dr_start),
        .dr_cmd   (dr_cmd),
        .dr_busy  (dr_busy),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .lb_we    (lb_we),
        .lb_x     (lb_x),
        .lb_pxl   (lb_pxl)
    );

    obj_linebuf u_linebuf (
        .clk      (clk),
        .rst      (rst),
        .vrender  (vrender),
        .lb_we    (lb_we),
        .lb_x     (lb_x),
        .lb_pxl   (lb_pxl),
        .hdump    (hdump),
        .obj_pxl  (obj_pxl)
    );

endmodule

// File: verilog/obj_linebuf.sv
/*
  Double-banked sprite line buffer: one bank is drawn while
  the other plays back by hdump and is cleared behind the read
*/
`timescale 1ns/1ns
`include "obj_defs.svh"

module obj_linebuf (
    input  logic                    clk,
    input  logic                    rst,

    input  logic [8:0]              vrender,

    input  logic                    lb_we,
    input  logic [`OBJ_LINE_W-1:0]  lb_x,
    input  obj_pkg::obj_pixel_t     lb_pxl,

    input  logic [`OBJ_LINE_W-1:0]  hdump,
    output obj_pkg::obj_pixel_t     obj_pxl
);
    import obj_pkg::*;

    localparam int DEPTH = 1 << `OBJ_LINE_W;

    logic                   wr_bank;
    logic                   clr_en;
    logic                   clr_bank;
    logic [`OBJ_LINE_W-1:0] clr_x;
    obj_pixel_t             rd_pxl [2];

    assign wr_bank = vrender[0];

    genvar b;
    generate
        for (b = 0; b < 2; b++) begin : g_bank
            obj_pixel_t mem [0:DEPTH-1];

            assign rd_pxl[b] = mem[hdump];

            always_ff @(posedge clk) begin
                // Drawing wins when a bank swap meets a pending clear
                if (wr_bank == 1'(b) && lb_we) begin
                    mem[lb_x] <= lb_pxl;
                end else if (clr_en && clr_bank == 1'(b)) begin
                    mem[clr_x] <= '0;
                end
            end
        end
    endgenerate

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            obj_pxl <= '0;
            clr_en  <= 1'b0;
        end else begin
            obj_pxl <= rd_pxl[~wr_bank];   // Playback bank
            clr_en  <= 1'b1;
        end
    end

    // Entry read on this cycle is cleared on the next
    always_ff @(posedge clk) begin
        clr_x    <= hdump;
        clr_bank <= ~wr_bank;
    end

endmodule

// File: obj_draw/obj_draw.sv
/*
  Sprite row drawer: fetches ROM words for one command and
  writes its pens to the line buffer until the end pen
*/
`timescale 1ns/1ns
`include "obj_defs.svh"

module obj_draw (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    dr_start,
    input  obj_pkg::draw_cmd_t      dr_cmd,
    output logic                    dr_busy,

    output logic [19:0]             rom_addr,
    input  logic [15:0]             rom_data,

    output logic                    lb_we,
    output logic [`OBJ_LINE_W-1:0]  lb_x,
    output obj_pkg::obj_pixel_t     lb_pxl
);
    import obj_pkg::*;

    typedef enum logic [1:0] {
        DR_IDLE,
        DR_FETCH,   // First address on the bus
        DR_LOAD,    // ROM word arrives
        DR_PLOT     // One pen per cycle
    } draw_state_t;

    draw_state_t            st;
    draw_cmd_t              cmd;
    logic [15:0]            waddr;     // {offset[14:0], word select}
    logic [15:0]            pens;
    logic [1:0]             ncnt;      // Nibble counter
    logic [`OBJ_LINE_W-1:0] x;
    logic                   hflip;
    logic [3:0]             pen;

    assign hflip    = cmd.offset[15];
    assign pen      = hflip ? pens[3:0] : pens[15:12];
    assign rom_addr = {cmd.bank, waddr};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st      <= DR_IDLE;
            dr_busy <= 1'b0;
            lb_we   <= 1'b0;
        end else begin
            lb_we <= 1'b0;
            case (st)
                DR_IDLE: begin
                    if (dr_start) begin
                        dr_busy <= 1'b1;
                        st      <= DR_FETCH;
                    end
                end
                DR_FETCH: st <= DR_LOAD;
                DR_LOAD:  st <= DR_PLOT;
                DR_PLOT: begin
                    if (pen == `OBJ_PEN_END) begin
                        dr_busy <= 1'b0;
                        st      <= DR_IDLE;
                    end else begin
                        lb_we <= pen != `OBJ_PEN_CLEAR;
                        if (&x) begin
                            dr_busy <= 1'b0;    // Ran off the buffer
                            st      <= DR_IDLE;
                        end else if (ncnt == 2'd3) begin
                            st <= DR_LOAD;
                        end
                    end
                end
                default: st <= DR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            DR_IDLE: begin
                if (dr_start) begin
                    cmd   <= dr_cmd;
                    waddr <= {dr_cmd.offset[14:0], 1'b0};
                    x     <= dr_cmd.xpos;
                end
            end
            DR_LOAD: begin
                pens  <= rom_data;
                ncnt  <= 2'd0;
                // Next word is on the bus while this one is plotted
                waddr <= hflip ? waddr - 1'b1 : waddr + 1'b1;
            end
            DR_PLOT: begin
                lb_x        <= x;
                lb_pxl.pal  <= cmd.pal;
                lb_pxl.pen  <= pen;
                lb_pxl.prio <= cmd.prio;
                x           <= x + 1'b1;
                ncnt        <= ncnt + 1'b1;
                pens        <= hflip ? pens >> 4 : pens << 4;
            end
            default: ;
        endcase
    end

endmodule

// File: obj_scan/obj_scan.sv
/*
  Object table scanner: walks the 128 objects for the next line,
  keeps the scratch ROM offset of each sprite up to date and
  hands decoded draw commands to the drawer
*/
`timescale 1ns/1ns
`include "obj_defs.svh"

module obj_scan (
    input  logic                    clk,
    input  logic                    rst,

    output logic [`OBJ_TBL_AW-1:0]  tbl_addr,
    output logic [15:0]             tbl_din,
    output logic                    tbl_we,
    input  logic [15:0]             tbl_dout,

    input  logic                    hstart,
    input  logic [8:0]              vrender,
    input  logic                    flip,

    output logic                    dr_start,
    output obj_pkg::draw_cmd_t      dr_cmd,
    input  logic                    dr_busy
);
    import obj_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_NEXT,    // Address of word 0 on the bus
        ST_TOP,     // Word 0 arrives
        ST_XPOS,
        ST_PITCH,
        ST_OFFS,
        ST_ATTR,
        ST_SCR,     // Scratch word arrives
        ST_DRAW
    } scan_state_t;

    scan_state_t          st;
    logic [`OBJ_IDX_W-1:0] cur_obj;
    logic [2:0]            idx;        // Word within the object
    logic                  first;      // Sprite starts on this line
    logic [15:0]           pitch;
    draw_cmd_t             nxt;        // Command being assembled
    logic [15:0]           next_offset;
    logic [8:0]            vrf;
    logic [7:0]            top;
    logic [7:0]            bottom;
    logic                  inzone;
    logic                  line_ok;
    logic                  last_obj;

    assign vrf      = flip ? 9'd223 - vrender : vrender;
    assign line_ok  = vrf < 9'(`OBJ_VIS_LINES);
    assign top      = tbl_dout[7:0];
    assign bottom   = tbl_dout[15:8];
    // Never true when top >= bottom
    assign inzone   = vrf[7:0] >= top && bottom > vrf[7:0];
    assign last_obj = &cur_obj;

    assign tbl_addr = {cur_obj, idx};
    assign tbl_din  = nxt.offset;      // Written back while tbl_we is high

    // First line starts from word 4, later lines from the scratch word
    assign next_offset = (first ? nxt.offset : tbl_dout) + pitch;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st       <= ST_IDLE;
            cur_obj  <= '0;
            idx      <= '0;
            first    <= 1'b0;
            tbl_we   <= 1'b0;
            dr_start <= 1'b0;
        end else begin
            tbl_we   <= 1'b0;
            dr_start <= 1'b0;
            case (st)
                ST_IDLE: begin
                    cur_obj <= '0;
                    idx     <= '0;
                    if (hstart && line_ok) begin
                        st  <= ST_TOP;
                        idx <= 3'd2;
                    end
                end
                ST_NEXT: begin
                    st  <= ST_TOP;
                    idx <= 3'd2;
                end
                ST_TOP: begin
                    if (bottom >= `OBJ_END_BOTTOM) begin
                        st <= ST_IDLE;      // End of list
                    end else if (!inzone) begin
                        if (last_obj) begin
                            st <= ST_IDLE;
                        end else begin
                            cur_obj <= cur_obj + 1'b1;
                            idx     <= '0;
                            st      <= ST_NEXT;
                        end
                    end else begin
                        first <= top == vrf[7:0];
                        idx   <= 3'd3;
                        st    <= ST_XPOS;
                    end
                end
                ST_XPOS: begin
                    idx <= 3'd4;
                    st  <= ST_PITCH;
                end
                ST_PITCH: begin
                    idx <= 3'd5;
                    st  <= ST_OFFS;
                end
                ST_OFFS: begin
                    idx <= 3'd7;            // Scratch word
                    st  <= ST_ATTR;
                end
                ST_ATTR: st <= ST_SCR;
                ST_SCR: begin
                    tbl_we <= 1'b1;         // Address still points at scratch
                    st     <= ST_DRAW;
                end
                ST_DRAW: begin
                    if (!dr_busy) begin
                        dr_start <= 1'b1;
                        if (last_obj) begin
                            st <= ST_IDLE;
                        end else begin
                            cur_obj <= cur_obj + 1'b1;
                            idx     <= '0;
                            st      <= ST_NEXT;
                        end
                    end else if (hstart) begin
                        // New line while the drawer is still busy
                        cur_obj <= '0;
                        idx     <= '0;
                        st      <= line_ok ? ST_NEXT : ST_IDLE;
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            ST_XPOS:  nxt.xpos   <= tbl_dout[`OBJ_LINE_W-1:0];
            ST_PITCH: pitch      <= tbl_dout;
            ST_OFFS:  nxt.offset <= tbl_dout;
            ST_ATTR: begin
                nxt.pal  <= tbl_dout[13:8];
                nxt.bank <= {1'b0, tbl_dout[6:4]};
                nxt.prio <= tbl_dout[1:0];
            end
            ST_SCR:   nxt.offset <= next_offset;
            ST_DRAW: begin
                if (!dr_busy) begin
                    dr_cmd <= nxt;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/obj_table.sv
/*
  Object table RAM, 1K x 16, CPU write port and scanner
  read/write port
*/
`timescale 1ns/1ns
`include "obj_defs.svh"

module obj_table (
    input  logic                    clk,

    input  logic                    cpu_we,
    input  logic [`OBJ_TBL_AW-1:0]  cpu_addr,
    input  logic [15:0]             cpu_din,

    input  logic [`OBJ_TBL_AW-1:0]  tbl_addr,
    input  logic                    tbl_we,
    input  logic [15:0]             tbl_din,
    output logic [15:0]             tbl_dout
);
    logic [15:0] mem [0:(1 << `OBJ_TBL_AW)-1];
    logic        tbl_wr_ok;

    // Scanner write is dropped on an address clash with the CPU
    assign tbl_wr_ok = tbl_we && !(cpu_we && cpu_addr == tbl_addr);

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        if (tbl_wr_ok) begin
            mem[tbl_addr] <= tbl_din;
        end
        tbl_dout <= mem[tbl_addr];  // Data ready on the next cycle
    end

endmodule

// File: common/obj_pkg.sv
/*
  Shared types of the sprite engine: the draw command passed
  from scanner to drawer, and the line buffer pixel
*/
`include "obj_defs.svh"

package obj_pkg;

    // One sprite row as decoded from the object table
    typedef struct packed {
        logic [`OBJ_LINE_W-1:0] xpos;     // First x of the row
        logic [15:0]            offset;   // Top bit is the horizontal flip
        logic [3:0]             bank;     // ROM bank
        logic [1:0]             prio;
        logic [5:0]             pal;
    } draw_cmd_t;

    // Line buffer entry, pen 0 is transparent
    typedef struct packed {
        logic [5:0] pal;
        logic [3:0] pen;
        logic [1:0] prio;       // Only carried to the output
    } obj_pixel_t;

endpackage

// File: common/obj_defs.svh
/*
  Sprite engine constants: object table depth, line width,
  visible lines, pen codes and list end marker
*/
`ifndef OBJ_DEFS_SVH
`define OBJ_DEFS_SVH

`define OBJ_IDX_W      7       // 128 objects
`define OBJ_TBL_AW     10      // 8 words per object
`define OBJ_VIS_LINES  224
`define OBJ_LINE_W     9       // x and line counters

`define OBJ_PEN_CLEAR  4'd0    // Transparent
`define OBJ_PEN_END    4'd15   // Ends a sprite row

// A bottom value at or above this ends the object list
`define OBJ_END_BOTTOM 8'hf0

`endif
